//--- source/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // datapath widths
    parameter int XLEN       = 32;
    parameter int REG_ADDR_W = 5;    // x0..x31

    // operations that reach the memory stage from execute
    // anything that is not a load or store shows up as OP_ALU
    typedef enum logic [7:0] {
        OP_NOP = 8'h00,
        OP_ALU = 8'h01,    // plain result, passes straight through

        // stores
        OP_SB  = 8'h10,
        OP_SH  = 8'h11,
        OP_SW  = 8'h12,

        // loads, signed then unsigned
        OP_LB  = 8'h20,
        OP_LH  = 8'h21,
        OP_LW  = 8'h22,
        OP_LBU = 8'h23,
        OP_LHU = 8'h24
    } alu_op_e;

    // access size sent to the data RAM
    typedef enum logic [1:0] {
        MEM_NOP  = 2'b00,
        MEM_BYTE = 2'b01,
        MEM_HALF = 2'b10,
        MEM_WORD = 2'b11
    } mem_sel_e;

endpackage

`default_nettype wire

//--- source/load_align.sv
`timescale 1ns/1ps
`default_nettype none

module load_align (
    input  mem_pkg::alu_op_e          op_i,
    input  logic [1:0]                addr_lo_i,
    input  logic [mem_pkg::XLEN-1:0]  word_i,
    output logic [mem_pkg::XLEN-1:0]  data_o
);

    logic [7:0]  byte_val;
    logic [15:0] half_val;

    // little endian lane pick
    assign byte_val = word_i[8*addr_lo_i +: 8];
    assign half_val = addr_lo_i[1] ? word_i[31:16] : word_i[15:0];    // bit 0 ignored

    always_comb begin
        case (op_i)
            mem_pkg::OP_LB: begin
                data_o = {{(mem_pkg::XLEN-8){byte_val[7]}}, byte_val};
            end
            mem_pkg::OP_LBU: begin
                data_o = {{(mem_pkg::XLEN-8){1'b0}}, byte_val};
            end
            mem_pkg::OP_LH: begin
                data_o = {{(mem_pkg::XLEN-16){half_val[15]}}, half_val};
            end
            mem_pkg::OP_LHU: begin
                data_o = {{(mem_pkg::XLEN-16){1'b0}}, half_val};
            end
            default: begin
                data_o = word_i;    // LW, and don't care for the rest
            end
        endcase
    end

endmodule

`default_nettype wire

//--- source/data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module data_ram #(
    parameter int ADDR_WIDTH = 10
) (
    input  logic                      clk_i,
    input  logic [ADDR_WIDTH-1:0]     addr_i,
    input  logic                      we_i,
    input  mem_pkg::mem_sel_e         sel_i,
    input  logic [mem_pkg::XLEN-1:0]  wdata_i,
    output logic [mem_pkg::XLEN-1:0]  rdata_o
);

    localparam int LANES = mem_pkg::XLEN / 8;
    localparam int DEPTH = 2 ** (ADDR_WIDTH - 2);

    // one word per entry, split into byte lanes
    logic [LANES-1:0][7:0] mem [DEPTH];

    logic [ADDR_WIDTH-3:0]     word_idx;
    logic [LANES-1:0]          lane_en;
    logic [mem_pkg::XLEN-1:0]  wdata_rep;

    assign word_idx = addr_i[ADDR_WIDTH-1:2];

    // lane enables and replicated store data
    always_comb begin
        case (sel_i)
            mem_pkg::MEM_BYTE: begin
                lane_en   = LANES'(1'b1) << addr_i[1:0];
                wdata_rep = {LANES{wdata_i[7:0]}};
            end
            mem_pkg::MEM_HALF: begin
                lane_en   = LANES'(2'b11) << {addr_i[1], 1'b0};
                wdata_rep = {(LANES/2){wdata_i[15:0]}};
            end
            mem_pkg::MEM_WORD: begin
                lane_en   = '1;
                wdata_rep = wdata_i;
            end
            default: begin
                lane_en   = '0;    // nothing to write
                wdata_rep = wdata_i;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            for (int i = 0; i < LANES; i++) begin
                if (lane_en[i]) begin
                    mem[word_idx][i] <= wdata_rep[8*i +: 8];
                end
            end
        end
    end

    // combinational read, whole aligned word
    assign rdata_o = mem[word_idx];

endmodule

`default_nettype wire

//--- source/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage #(
    parameter int ADDR_WIDTH = 10
) (
    input  logic                            clk_i,
    input  logic                            rst_i,

    // from execute
    input  mem_pkg::alu_op_e                aluop_i,
    input  logic [mem_pkg::REG_ADDR_W-1:0]  rd_i,
    input  logic [mem_pkg::XLEN-1:0]        wdata_i,
    input  logic                            wreg_i,
    input  logic [mem_pkg::XLEN-1:0]        mem_reg2_i,    // rs2, store data
    input  logic [ADDR_WIDTH-1:0]           mem_addr_i,

    // data RAM side
    input  logic [mem_pkg::XLEN-1:0]        ram_rdata_i,
    output logic [ADDR_WIDTH-1:0]           ram_addr_o,
    output logic                            ram_we_o,
    output mem_pkg::mem_sel_e               ram_sel_o,
    output logic [mem_pkg::XLEN-1:0]        ram_wdata_o,

    // to writeback
    output logic [mem_pkg::REG_ADDR_W-1:0]  rd_o,
    output logic [mem_pkg::XLEN-1:0]        wdata_o,
    output logic                            wreg_o
);

    mem_pkg::mem_sel_e         sel;
    logic                      is_store;
    logic                      is_load;
    logic [mem_pkg::XLEN-1:0]  load_data;
    logic [mem_pkg::XLEN-1:0]  wb_data;

    // operation decode into a RAM request
    always_comb begin
        sel      = mem_pkg::MEM_NOP;
        is_store = 1'b0;
        is_load  = 1'b0;
        case (aluop_i)
            mem_pkg::OP_SB: begin
                sel      = mem_pkg::MEM_BYTE;
                is_store = 1'b1;
            end
            mem_pkg::OP_SH: begin
                sel      = mem_pkg::MEM_HALF;
                is_store = 1'b1;
            end
            mem_pkg::OP_SW: begin
                sel      = mem_pkg::MEM_WORD;
                is_store = 1'b1;
            end
            mem_pkg::OP_LB, mem_pkg::OP_LBU: begin
                sel     = mem_pkg::MEM_BYTE;
                is_load = 1'b1;
            end
            mem_pkg::OP_LH, mem_pkg::OP_LHU: begin
                sel     = mem_pkg::MEM_HALF;
                is_load = 1'b1;
            end
            mem_pkg::OP_LW: begin
                sel     = mem_pkg::MEM_WORD;
                is_load = 1'b1;
            end
            default: ;    // NOP and ALU results leave memory alone
        endcase
    end

    assign ram_addr_o  = mem_addr_i;
    assign ram_sel_o   = sel;
    assign ram_wdata_o = mem_reg2_i;    // RAM does the lane replication
    assign ram_we_o    = is_store & ~rst_i;    // no writes while in reset

    load_align u_load_align (
        .op_i      (aluop_i),
        .addr_lo_i (mem_addr_i[1:0]),
        .word_i    (ram_rdata_i),
        .data_o    (load_data)
    );

    assign wb_data = is_load ? load_data : wdata_i;

    // writeback register, one cycle latency
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rd_o    <= '0;
            wdata_o <= '0;
            wreg_o  <= 1'b0;
        end else begin
            rd_o    <= rd_i;
            wdata_o <= wb_data;
            wreg_o  <= wreg_i;
        end
    end

endmodule

`default_nettype wire

//--- source/mem_access_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_access_top #(
    parameter int ADDR_WIDTH = 10    // byte address width, 4..16
) (
    input  logic                            clk_i,
    input  logic                            rst_i,

    input  mem_pkg::alu_op_e                aluop_i,
    input  logic [mem_pkg::REG_ADDR_W-1:0]  rd_i,
    input  logic [mem_pkg::XLEN-1:0]        wdata_i,
    input  logic                            wreg_i,
    input  logic [mem_pkg::XLEN-1:0]        mem_reg2_i,
    input  logic [ADDR_WIDTH-1:0]           mem_addr_i,

    output logic [mem_pkg::REG_ADDR_W-1:0]  rd_o,
    output logic [mem_pkg::XLEN-1:0]        wdata_o,
    output logic                            wreg_o
);

    // stage to RAM
    logic [ADDR_WIDTH-1:0]     ram_addr;
    logic                      ram_we;
    mem_pkg::mem_sel_e         ram_sel;
    logic [mem_pkg::XLEN-1:0]  ram_wdata;
    logic [mem_pkg::XLEN-1:0]  ram_rdata;    // aligned word back to the stage

    mem_stage #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_mem_stage (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .aluop_i     (aluop_i),
        .rd_i        (rd_i),
        .wdata_i     (wdata_i),
        .wreg_i      (wreg_i),
        .mem_reg2_i  (mem_reg2_i),
        .mem_addr_i  (mem_addr_i),
        .ram_rdata_i (ram_rdata),
        .ram_addr_o  (ram_addr),
        .ram_we_o    (ram_we),
        .ram_sel_o   (ram_sel),
        .ram_wdata_o (ram_wdata),
        .rd_o        (rd_o),
        .wdata_o     (wdata_o),
        .wreg_o      (wreg_o)
    );

    data_ram #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_data_ram (
        .clk_i   (clk_i),
        .addr_i  (ram_addr),
        .we_i    (ram_we),
        .sel_i   (ram_sel),
        .wdata_i (ram_wdata),
        .rdata_o (ram_rdata)
    );

endmodule

`default_nettype wire

//--- bench/mem_access_properties.sv
`timescale 1ns/1ps
`default_nettype none

module mem_access_properties (
    input logic               clk_i,
    input logic               rst_i,
    input mem_pkg::alu_op_e   aluop_i,
    input logic               ram_we_i,
    input mem_pkg::mem_sel_e  ram_sel_i,
    input logic               wb_wreg_i    // registered wreg_o of the stage
);

    logic is_store;
    logic is_non_mem;

    assign is_store   = aluop_i == mem_pkg::OP_SB || aluop_i == mem_pkg::OP_SH ||
                        aluop_i == mem_pkg::OP_SW;
    assign is_non_mem = aluop_i == mem_pkg::OP_NOP || aluop_i == mem_pkg::OP_ALU;

    // RAM only written by stores
    we_only_on_store: assert property (@(posedge clk_i) ram_we_i |-> is_store)
        else $error("RAM write enable high without a store operation");

    wreg_low_after_reset: assert property (@(posedge clk_i) rst_i |=> !wb_wreg_i)
        else $error("wreg_o high in the cycle after reset was asserted");

    no_size_for_non_mem: assert property (@(posedge clk_i)
        is_non_mem |-> ram_sel_i == mem_pkg::MEM_NOP)
        else $error("non-memory operation drove a RAM access size");

endmodule

bind mem_stage mem_access_properties u_props (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .aluop_i   (aluop_i),
    .ram_we_i  (ram_we_o),
    .ram_sel_i (ram_sel_o),
    .wb_wreg_i (wreg_o)
);

`default_nettype wire

//--- bench/tb_mem_access.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_access;

    localparam int ADDR_WIDTH = 10;
    localparam int WIN        = 64;    // byte window used by all tests

    logic                            clk_i;
    logic                            rst_i;
    mem_pkg::alu_op_e                aluop_i;
    logic [mem_pkg::REG_ADDR_W-1:0]  rd_i;
    logic [mem_pkg::XLEN-1:0]        wdata_i;
    logic                            wreg_i;
    logic [mem_pkg::XLEN-1:0]        mem_reg2_i;
    logic [ADDR_WIDTH-1:0]           mem_addr_i;
    logic [mem_pkg::REG_ADDR_W-1:0]  rd_o;
    logic [mem_pkg::XLEN-1:0]        wdata_o;
    logic                            wreg_o;

    logic [7:0]  shadow [WIN];    // mirrors every store
    logic [4:0]  exp_rd_q [$];
    logic [31:0] exp_data_q [$];
    logic        exp_wreg_q [$];
    int          exp_cyc_q [$];    // issue cycle of each entry
    int          cycle_cnt = 0;
    int          test_err = 0;
    int          total_err = 0;
    int          n_tests = 0;
    string       cur_test = "reset";
    integer      seed;

    mem_access_top #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) uut (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .aluop_i    (aluop_i),
        .rd_i       (rd_i),
        .wdata_i    (wdata_i),
        .wreg_i     (wreg_i),
        .mem_reg2_i (mem_reg2_i),
        .mem_addr_i (mem_addr_i),
        .rd_o       (rd_o),
        .wdata_o    (wdata_o),
        .wreg_o     (wreg_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

    // loads read the shadow bytes little endian
    // every other op passes wdata through
    function automatic logic [31:0] expected_result(
        input mem_pkg::alu_op_e op,
        input logic [5:0]       addr,
        input logic [31:0]      wdata,
        input logic [7:0]       mem [WIN]
    );
        logic [5:0]  hb;
        logic [5:0]  wb;
        logic [7:0]  b;
        logic [15:0] h;
        hb = {addr[5:1], 1'b0};    // bit 0 ignored
        wb = {addr[5:2], 2'b00};
        b  = mem[addr];
        h  = {mem[hb + 6'd1], mem[hb]};
        case (op)
            mem_pkg::OP_LB:  return {{24{b[7]}}, b};
            mem_pkg::OP_LBU: return {24'h0, b};
            mem_pkg::OP_LH:  return {{16{h[15]}}, h};
            mem_pkg::OP_LHU: return {16'h0, h};
            mem_pkg::OP_LW:  return {mem[wb + 6'd3], mem[wb + 6'd2],
                                     mem[wb + 6'd1], mem[wb]};
            default:         return wdata;
        endcase
    endfunction

    task automatic update_shadow(input mem_pkg::alu_op_e op, input logic [5:0] addr,
                                 input logic [31:0] val);
        case (op)
            mem_pkg::OP_SB: shadow[addr] = val[7:0];
            mem_pkg::OP_SH: begin
                for (int i = 0; i < 2; i++) begin
                    shadow[{addr[5:1], 1'(i)}] = val[8*i +: 8];
                end
            end
            mem_pkg::OP_SW: begin
                for (int i = 0; i < 4; i++) begin
                    shadow[{addr[5:2], 2'(i)}] = val[8*i +: 8];
                end
            end
            default: ;
        endcase
    endtask

    // drive one operation and queue what writeback should show next cycle
    task automatic issue(input mem_pkg::alu_op_e op, input logic [5:0] addr,
                         input logic [31:0] reg2, input logic [31:0] wdata,
                         input logic [4:0] rd, input logic wreg);
        @(posedge clk_i);
        #2;
        aluop_i    = op;
        mem_addr_i = ADDR_WIDTH'(addr);
        mem_reg2_i = reg2;
        wdata_i    = wdata;
        rd_i       = rd;
        wreg_i     = wreg;
        exp_rd_q.push_back(rd);
        exp_data_q.push_back(expected_result(op, addr, wdata, shadow));
        exp_wreg_q.push_back(wreg);
        exp_cyc_q.push_back(cycle_cnt);
        update_shadow(op, addr, reg2);
    endtask

    task automatic set_idle();
        aluop_i    = mem_pkg::OP_NOP;
        rd_i       = '0;
        wdata_i    = '0;
        wreg_i     = 1'b0;
        mem_reg2_i = '0;
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        test_err = 0;
    endtask

    task automatic finish_test();
        int t;
        @(posedge clk_i);
        #2;
        set_idle();
        t = 0;
        while (exp_cyc_q.size() > 0 && t < 10) begin
            @(posedge clk_i);
            t++;
        end
        if (exp_cyc_q.size() > 0) begin
            $display("error: %s timed out with %0d writeback results never compared",
                     cur_test, exp_cyc_q.size());
            test_err++;
            exp_rd_q.delete();
            exp_data_q.delete();
            exp_wreg_q.delete();
            exp_cyc_q.delete();
        end
        total_err += test_err;
        n_tests++;
        $display("test %-14s %s, %0d errors", cur_test, (test_err == 0) ? "ok" : "failed",
                 test_err);
    endtask

    task automatic check_reset_outputs();
        assert (wreg_o === 1'b0 && rd_o === '0 && wdata_o === '0) else begin
            $display("mismatch %s: expected wreg 0 rd 0 wdata 0, actual wreg %b rd %0d wdata %h",
                     cur_test, wreg_o, rd_o, wdata_o);
            test_err++;
        end
    endtask

    // writeback compared at the falling edge one cycle after issue
    always @(negedge clk_i) begin
        if (exp_cyc_q.size() > 0 && exp_cyc_q[0] == cycle_cnt - 1) begin
            assert (wreg_o === exp_wreg_q[0]) else begin
                $display("mismatch %s wreg: expected %b actual %b", cur_test, exp_wreg_q[0], wreg_o);
                test_err++;
            end
            assert (rd_o === exp_rd_q[0]) else begin
                $display("mismatch %s rd: expected %0d actual %0d", cur_test, exp_rd_q[0], rd_o);
                test_err++;
            end
            assert (wdata_o === exp_data_q[0]) else begin
                $display("mismatch %s wdata: expected %h actual %h", cur_test, exp_data_q[0],
                         wdata_o);
                test_err++;
            end
            void'(exp_rd_q.pop_front());
            void'(exp_data_q.pop_front());
            void'(exp_wreg_q.pop_front());
            void'(exp_cyc_q.pop_front());
        end
    end

    initial begin
        mem_pkg::alu_op_e ld_ops [5];
        mem_pkg::alu_op_e all_ops [10];
        int               k;
        logic [31:0]      v;
        ld_ops  = '{mem_pkg::OP_LW, mem_pkg::OP_LB, mem_pkg::OP_LBU, mem_pkg::OP_LH,
                    mem_pkg::OP_LHU};
        all_ops = '{mem_pkg::OP_NOP, mem_pkg::OP_ALU, mem_pkg::OP_SB, mem_pkg::OP_SH,
                    mem_pkg::OP_SW, mem_pkg::OP_LB, mem_pkg::OP_LH, mem_pkg::OP_LW,
                    mem_pkg::OP_LBU, mem_pkg::OP_LHU};
        seed = 32'h3f7d_0c36;

        // nonzero inputs during reset must not reach writeback
        rst_i      = 1'b1;
        aluop_i    = mem_pkg::OP_ALU;
        rd_i       = 5'h1f;
        wdata_i    = 32'hdead_beef;
        wreg_i     = 1'b1;
        mem_reg2_i = 32'h0;
        mem_addr_i = '0;
        start_test("reset");
        repeat (7) begin
            @(negedge clk_i);
            check_reset_outputs();
        end
        @(posedge clk_i);
        #2;
        rst_i = 1'b0;
        set_idle();
        @(negedge clk_i);
        check_reset_outputs();
        finish_test();

        start_test("fill");    // known contents for the whole window
        for (int w = 0; w < WIN; w += 4) begin
            issue(mem_pkg::OP_SW, 6'(w), 32'h9e37_79b9 * 32'(w + 1), 32'h0, 5'd0, 1'b0);
        end
        finish_test();

        start_test("word_trip");
        issue(mem_pkg::OP_SW, 6'd8, 32'h8bad_f00d, 32'h0, 5'd0, 1'b0);
        issue(mem_pkg::OP_LW, 6'd8, 32'h0, 32'h0, 5'd7, 1'b1);
        issue(mem_pkg::OP_SW, 6'd13, 32'h0123_4567, 32'h0, 5'd0, 1'b0);
        issue(mem_pkg::OP_LW, 6'd14, 32'h0, 32'h0, 5'd8, 1'b1);
        finish_test();

        start_test("byte_half");
        for (int i = 0; i < 4; i++) begin
            issue(mem_pkg::OP_SB, 6'(16 + i), 32'h0000_1150 + 32'(i * 35), 32'h0, 5'd0, 1'b0);
        end
        issue(mem_pkg::OP_SH, 6'd22, 32'hcafe_8a17, 32'h0, 5'd0, 1'b0);
        issue(mem_pkg::OP_SH, 6'd25, 32'h1234_f00d, 32'h0, 5'd0, 1'b0);
        for (int a = 16; a < 28; a++) begin
            for (int j = 0; j < 5; j++) begin
                issue(ld_ops[j], 6'(a), 32'h0, 32'hffff_ffff, 5'(a), 1'b1);
            end
        end
        finish_test();

        start_test("pass_through");
        issue(mem_pkg::OP_ALU, 6'd16, 32'hffff_ffff, 32'h1234_5678, 5'd9, 1'b1);
        issue(mem_pkg::OP_NOP, 6'd20, 32'hffff_ffff, 32'h0bad_cafe, 5'd3, 1'b0);
        issue(mem_pkg::OP_LW, 6'd16, 32'h0, 32'h0, 5'd10, 1'b1);
        issue(mem_pkg::OP_LW, 6'd20, 32'h0, 32'h0, 5'd11, 1'b1);
        finish_test();

        start_test("back_to_back");
        for (int i = 0; i < 4; i++) begin
            v = $random(seed);
            issue(mem_pkg::OP_SB, 6'(40 + i), v, 32'h0, 5'd0, 1'b0);
            issue(mem_pkg::OP_LBU, 6'(40 + i), 32'h0, 32'h0, 5'd12, 1'b1);
        end
        issue(mem_pkg::OP_SH, 6'd46, 32'h0000_9abc, 32'h0, 5'd0, 1'b0);
        issue(mem_pkg::OP_LH, 6'd46, 32'h0, 32'h0, 5'd13, 1'b1);
        finish_test();

        start_test("random_mix");
        for (int n = 0; n < 300; n++) begin
            k = $unsigned($random(seed)) % 10;
            issue(all_ops[k], 6'($random(seed)), $random(seed), $random(seed),
                  5'($random(seed)), 1'($random(seed)));
        end
        finish_test();

        $display("%0d tests run, %0d errors", n_tests, total_err);
        if (total_err == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
source/mem_pkg.sv
source/load_align.sv
source/data_ram.sv
source/mem_stage.sv
source/mem_access_top.sv
bench/mem_access_properties.sv
bench/tb_mem_access.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the memory stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_mem_access \
    -f filelist.f \
    -o sim_tb_mem_access

./obj_dir/sim_tb_mem_access | tee sim.log

if grep -q "TEST FAIL" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if ! grep -q "TEST PASS" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
